// ==== common/fc_pkg.sv ====
`default_nettype none

package fc_pkg;

    // ####################
    // Layer shape.
    localparam int NUM_INPUTS        = 12;
    localparam int NUM_NEURONS       = 16;
    localparam int NUM_WEIGHTS       = NUM_INPUTS * NUM_NEURONS;
    localparam int DATA_WIDTH        = 32;
    localparam int RESULT_FIFO_DEPTH = 8;  // Also the initial credit count.

    // ####################
    // Vector types.
    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic [3:0]                   neuron_idx_t;
    typedef logic [7:0]                   weight_addr_t;
    typedef logic [NUM_INPUTS-1:0]        sign_mask_t;   // 1 adds, 0 subtracts.
    typedef data_t [NUM_INPUTS-1:0]       data_vec_t;

    // ####################
    // Block-to-block bundles.
    typedef struct packed {
        logic        valid;
        neuron_idx_t neuron;
        sign_mask_t  mask;
        data_vec_t   data;
    } fc_beat_t;

    typedef struct packed {
        neuron_idx_t neuron;
        data_t       sum;
    } fc_result_t;

    typedef enum logic [1:0] {
        FIFO_EMPTY,
        FIFO_PARTIAL,
        FIFO_FULL
    } fifo_state_e;

endpackage

`default_nettype wire

// ==== intake/weight_store.sv ====
`default_nettype none

module weight_store import fc_pkg::*; (
    input  wire              clk,
    input  wire              rstn,
    input  wire              weight_bit,
    input  wire              weight_valid,
    output logic             weights_ready,
    input  wire neuron_idx_t neuron,
    output sign_mask_t       sign_mask
);

    weight_addr_t           wr_addr;
    logic [NUM_WEIGHTS-1:0] store;
    logic                   wr_en;

    assign weights_ready = (wr_addr == weight_addr_t'(NUM_WEIGHTS));
    assign wr_en         = weight_valid && !weights_ready;  // Extra bits are dropped.

    // Write counter stops at a full store.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_addr <= '0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            store[wr_addr] <= weight_bit;
        end
    end

    // Position is lane * 16 + neuron.
    always_comb begin
        for (int lane = 0; lane < NUM_INPUTS; lane++) begin
            sign_mask[lane] = store[lane * NUM_NEURONS + int'(neuron)];
        end
    end

endmodule

`default_nettype wire

// ==== intake/vector_intake.sv ====
`default_nettype none

module vector_intake import fc_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    input  wire             in_valid,
    input  wire data_vec_t  in_vector,
    output neuron_idx_t     neuron,
    input  wire sign_mask_t sign_mask,
    output fc_beat_t        beat
);

    neuron_idx_t neuron_cnt;
    logic        beat_valid;
    neuron_idx_t beat_neuron;
    sign_mask_t  beat_mask;
    data_vec_t   beat_data;

    assign neuron = neuron_cnt;  // Selects the weight column.

    // Wraps from 15 back to 0.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            neuron_cnt <= '0;
        end else if (in_valid) begin
            neuron_cnt <= neuron_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            beat_neuron <= neuron_cnt;
            beat_mask   <= sign_mask;
            beat_data   <= in_vector;
        end
    end

    assign beat = '{valid: beat_valid, neuron: beat_neuron, mask: beat_mask, data: beat_data};

endmodule

`default_nettype wire

// ==== adder_tree/sign_adder_tree.sv ====
`default_nettype none

module sign_adder_tree import fc_pkg::*; (
    input  wire           clk,
    input  wire           rstn,
    input  wire fc_beat_t beat,
    output logic          result_valid,
    output fc_result_t    result
);

    // One entry per register stage: sign, then levels 6, 3, 2, 1.
    logic        [4:0] vld;
    neuron_idx_t [4:0] idx;

    data_vec_t   terms;
    data_t [5:0] sum6;
    data_t [2:0] sum3;
    data_t [1:0] sum2;
    data_t       sum1;

    // ####################
    // Side band.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld <= '0;
        end else begin
            vld <= {vld[3:0], beat.valid};
        end
    end

    always_ff @(posedge clk) begin
        idx <= {idx[3:0], beat.neuron};
    end

    // ####################
    // Sign stage.
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_INPUTS; i++) begin
            terms[i] <= beat.mask[i] ? beat.data[i] : -beat.data[i];
        end
    end

    // ####################
    // Adder levels, all sums wrap at 32 bits.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 6; i++) begin
            sum6[i] <= terms[2*i] + terms[2*i+1];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            sum3[i] <= sum6[2*i] + sum6[2*i+1];
        end
    end

    always_ff @(posedge clk) begin
        sum2[0] <= sum3[0] + sum3[1];
        sum2[1] <= sum3[2];  // Odd one out rides along.
    end

    always_ff @(posedge clk) begin
        sum1 <= sum2[0] + sum2[1];
    end

    assign result_valid = vld[4];
    assign result       = '{neuron: idx[4], sum: sum1};

endmodule

`default_nettype wire

// ==== result_fifo/result_fifo.sv ====
`default_nettype none

module result_fifo import fc_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    input  wire             result_valid,
    input  wire fc_result_t result,
    output logic            out_valid,
    input  wire             out_ready,
    output fc_result_t      out_result,
    output logic            credit_return
);

    fc_result_t                             mem [RESULT_FIFO_DEPTH];
    logic [$clog2(RESULT_FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(RESULT_FIFO_DEPTH)-1:0]   rd_ptr;
    fifo_state_e                            state;
    logic                                   push;
    logic                                   pop;

    assign push       = result_valid;  // Credits keep this from overflowing.
    assign pop        = out_valid && out_ready;
    assign out_valid  = (state != FIFO_EMPTY);
    assign out_result = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= result;
        end
    end

    // ####################
    // Pointers and fill state.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            state         <= FIFO_EMPTY;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;  // One pulse per popped result.
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                state <= (wr_ptr + 1'b1 == rd_ptr) ? FIFO_FULL : FIFO_PARTIAL;
            end else if (pop && !push) begin
                state <= (rd_ptr + 1'b1 == wr_ptr) ? FIFO_EMPTY : FIFO_PARTIAL;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/fc_top.sv ====
`default_nettype none

module fc_top import fc_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    input  wire             weight_bit,
    input  wire             weight_valid,
    output logic            weights_ready,
    input  wire             in_valid,
    input  wire data_vec_t  in_vector,
    output logic            credit_return,
    output logic            out_valid,
    input  wire             out_ready,
    output fc_result_t      out_result
);

    neuron_idx_t neuron;
    sign_mask_t  sign_mask;
    fc_beat_t    beat;
    logic        result_valid;
    fc_result_t  result;

    weight_store u_weight_store (
        .clk           (clk),
        .rstn          (rstn),
        .weight_bit    (weight_bit),
        .weight_valid  (weight_valid),
        .weights_ready (weights_ready),
        .neuron        (neuron),
        .sign_mask     (sign_mask)
    );

    vector_intake u_vector_intake (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_vector (in_vector),
        .neuron    (neuron),
        .sign_mask (sign_mask),
        .beat      (beat)
    );

    sign_adder_tree u_sign_adder_tree (
        .clk          (clk),
        .rstn         (rstn),
        .beat         (beat),
        .result_valid (result_valid),
        .result       (result)
    );

    result_fifo u_result_fifo (
        .clk           (clk),
        .rstn          (rstn),
        .result_valid  (result_valid),
        .result        (result),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_result    (out_result),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

// ==== dv/fc_tb.sv ====
`default_nettype none

module fc_tb import fc_pkg::*; ();

    localparam int VEC_BASE  = NUM_WEIGHTS;
    localparam int VEC_WORDS = NUM_INPUTS + 2;  // Lanes, neuron, sum.
    localparam int NUM_VECS  = 40;
    localparam int MAX_CYCLES = 4 * (NUM_WEIGHTS + NUM_VECS * 8) + 500;

    logic       clk;
    logic       rstn;
    logic       weight_bit;
    logic       weight_valid;
    logic       weights_ready;
    logic       in_valid;
    data_vec_t  in_vector;
    logic       credit_return;
    logic       out_valid;
    logic       out_ready;
    fc_result_t out_result;

    logic [31:0] pat [0:VEC_BASE+NUM_VECS*VEC_WORDS-1];
    int          seed = 74259;
    int          errors;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          credits;
    int          sent;
    int          taken;
    int          returns;
    int          cycles;
    int          next_neuron;
    bit          random_ready;
    int          exp_idx [$];
    int          exp_nrn [$];
    int          taken_nrn [NUM_VECS];

    fc_top dut0 (
        .clk           (clk),
        .rstn          (rstn),
        .weight_bit    (weight_bit),
        .weight_valid  (weight_valid),
        .weights_ready (weights_ready),
        .in_valid      (in_valid),
        .in_vector     (in_vector),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_result    (out_result)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // Signed sum by the weight rule, wrapping at 32 bits.
    function automatic logic [31:0] model_sum(int i, int n);
        logic [31:0] sum;
        logic [31:0] d;
        sum = '0;
        for (int l = 0; l < NUM_INPUTS; l++) begin
            d = pat[VEC_BASE + i * VEC_WORDS + l];
            if (pat[l * NUM_NEURONS + n][0]) sum = sum + d;
            else                              sum = sum - d;
        end
        return sum;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // ####################
    // Result and credit monitor, sampled between edges.
    always @(negedge clk) begin
        int i;
        int n;
        out_ready = random_ready ? (($random(seed) & 3) != 0) : 1'b1;
        if (out_valid && out_ready) begin
            assert (exp_idx.size() > 0) else begin
                $display("Error at %0t: a result came out with no vector outstanding", $time);
                errors++;
            end
            if (exp_idx.size() > 0) begin
                i = exp_idx.pop_front();
                n = exp_nrn.pop_front();
                check_val("out_result.neuron", 32'(out_result.neuron), 32'(n));
                check_val("out_result.sum", out_result.sum, model_sum(i, n));
                taken_nrn[i] = 32'(out_result.neuron);
            end
            taken++;
        end
        if (credit_return) begin
            credits++;
            returns++;
        end
        assert (credits >= 0 && credits <= RESULT_FIFO_DEPTH) else begin
            $display("Error at %0t: source credit count %0d is out of range", $time, credits);
            errors++;
        end
    end

    // ####################
    // Stimulus tasks, each starts and ends on a falling edge.
    task automatic load_weights();
        for (int a = 0; a < NUM_WEIGHTS; a++) begin
            check_val("weights_ready", 32'(weights_ready), 32'd0);
            weight_valid = 1'b1;
            weight_bit   = pat[a][0];
            @(negedge clk);
        end
        weight_valid = 1'b0;
        check_val("weights_ready", 32'(weights_ready), 32'd1);
    endtask

    task automatic send_vector(int i, int gap);
        in_valid = 1'b0;
        repeat (gap) @(negedge clk);
        while (credits == 0) @(negedge clk);
        for (int l = 0; l < NUM_INPUTS; l++) begin
            in_vector[l] = pat[VEC_BASE + i * VEC_WORDS + l];
        end
        in_valid = 1'b1;
        credits--;
        sent++;
        exp_idx.push_back(i);
        exp_nrn.push_back(next_neuron);
        next_neuron = (next_neuron + 1) % NUM_NEURONS;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        while (taken != sent) @(negedge clk);
        waited = 0;
        // Credits trail the last pop by a short delay.
        while (credits != RESULT_FIFO_DEPTH && waited < RESULT_FIFO_DEPTH) begin
            @(negedge clk);
            waited++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        weight_bit   = 1'b0;
        weight_valid = 1'b0;
        in_valid     = 1'b0;
        in_vector    = '0;
        out_ready    = 1'b1;
        random_ready = 1'b0;
        credits      = RESULT_FIFO_DEPTH;
        $readmemh("dv/fc_patterns.txt", pat);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        check_val("out_valid", 32'(out_valid), 32'd0);
        check_val("credit_return", 32'(credit_return), 32'd0);
        check_val("weights_ready", 32'(weights_ready), 32'd0);
        load_weights();
        end_test("reset state and weight load");

        for (int i = 0; i < NUM_VECS; i++) begin
            check_val("pattern sum", pat[VEC_BASE + i * VEC_WORDS + 13],
                      model_sum(i, int'(pat[VEC_BASE + i * VEC_WORDS + 12])));
        end
        for (int i = 0; i < 20; i++) send_vector(i, $random(seed) & 3);
        wait_drain();
        end_test("dot products and indexing");

        for (int a = 0; a < 8; a++) begin
            weight_valid = 1'b1;
            weight_bit   = ~pat[a][0];  // Must be ignored.
            @(negedge clk);
        end
        weight_valid = 1'b0;
        check_val("weights_ready", 32'(weights_ready), 32'd1);
        for (int i = 20; i < 28; i++) send_vector(i, 0);
        wait_drain();
        end_test("extra weight bits");

        random_ready = 1'b1;
        for (int i = 28; i < 36; i++) send_vector(i, 0);
        wait_drain();
        random_ready = 1'b0;
        end_test("back-pressure");

        check_val("credit returns", 32'(returns), 32'(taken));
        check_val("credits", 32'(credits), 32'(RESULT_FIFO_DEPTH));
        end_test("credit accounting");

        rstn = 1'b0;
        repeat (3) @(negedge clk);
        check_val("weights_ready", 32'(weights_ready), 32'd0);
        check_val("out_valid", 32'(out_valid), 32'd0);
        rstn        = 1'b1;
        next_neuron = 0;
        load_weights();
        for (int i = 36; i < NUM_VECS; i++) send_vector(i, 1);
        wait_drain();
        check_val("first neuron after reset", 32'(taken_nrn[36]), 32'd0);
        end_test("mid-run reset");

        $display("tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/fc_patterns.txt ====
// Words 0..191: weight bits, one line per input lane, neurons 0..15 left to right.
// Then one row per vector: lanes 0..11, expected neuron, expected sum.
0 1 1 1 1 1 1 1 1 1 1 1 1 0 1 1
0 0 1 1 1 1 1 1 1 1 1 1 1 0 0 1
0 0 0 1 1 1 1 1 1 1 1 1 1 0 0 0
0 0 0 0 1 1 1 1 1 1 1 1 1 0 0 0
0 0 0 0 0 1 1 1 1 1 1 1 1 0 0 0
0 0 0 0 0 0 1 1 1 1 1 1 1 0 0 0
0 0 0 0 0 0 0 1 1 1 1 1 1 0 0 0
0 0 0 0 0 0 0 0 1 1 1 1 1 0 0 0
0 0 0 0 0 0 0 0 0 1 1 1 1 0 0 0
0 0 0 0 0 0 0 0 0 0 1 1 1 0 0 0
0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0
1000 1 1 1 1 1 1 1 1 1 1 1 0 FFFFEFF5
1001 1 1 1 1 1 1 1 1 1 1 1 1 FF6
1002 1 1 1 1 1 1 1 1 1 1 1 2 FF9
1003 1 1 1 1 1 1 1 1 1 1 1 3 FFC
1004 1 1 1 1 1 1 1 1 1 1 1 4 FFF
1005 40000000 40000000 40000000 40000000 40000000 40000000
40000000 40000000 40000000 40000000 40000000 5 40001005
1006 1 1 1 1 1 1 1 1 1 1 1 6 1005
1007 1 1 1 1 1 1 1 1 1 1 1 7 1008
1008 1 1 1 1 1 1 1 1 1 1 1 8 100B
1009 1 1 1 1 1 1 1 1 1 1 1 9 100E
100A 1 1 1 1 1 1 1 1 1 1 1 A 1011
100B 1 1 1 1 1 1 1 1 1 1 1 B 1014
100C 1 1 1 1 1 1 1 1 1 1 1 C 1017
100D 40000000 40000000 40000000 40000000 40000000 40000000
40000000 40000000 40000000 40000000 40000000 D 3FFFEFF3
100E 1 1 1 1 1 1 1 1 1 1 1 E 1003
100F 1 1 1 1 1 1 1 1 1 1 1 F 1006
1010 1 1 1 1 1 1 1 1 1 1 1 0 FFFFEFE5
1011 1 1 1 1 1 1 1 1 1 1 1 1 1006
1012 1 1 1 1 1 1 1 1 1 1 1 2 1009
1013 1 1 1 1 1 1 1 1 1 1 1 3 100C
1014 1 1 1 1 1 1 1 1 1 1 1 4 100F
1015 1 1 1 1 1 1 1 1 1 1 1 5 1012
1016 40000000 40000000 40000000 40000000 40000000 40000000
40000000 40000000 40000000 40000000 40000000 6 C0001016
1017 1 1 1 1 1 1 1 1 1 1 1 7 1018
1018 1 1 1 1 1 1 1 1 1 1 1 8 101B
1019 1 1 1 1 1 1 1 1 1 1 1 9 101E
101A 1 1 1 1 1 1 1 1 1 1 1 A 1021
101B 1 1 1 1 1 1 1 1 1 1 1 B 1024
101C 1 1 1 1 1 1 1 1 1 1 1 C 1027
101D 1 1 1 1 1 1 1 1 1 1 1 D FFFFEFD8
101E 40000000 40000000 40000000 40000000 40000000 40000000
40000000 40000000 40000000 40000000 40000000 E 4000101E
101F 1 1 1 1 1 1 1 1 1 1 1 F 1016
1020 1 1 1 1 1 1 1 1 1 1 1 0 FFFFEFD5
1021 1 1 1 1 1 1 1 1 1 1 1 1 1016
1022 1 1 1 1 1 1 1 1 1 1 1 2 1019
1023 1 1 1 1 1 1 1 1 1 1 1 3 101C
1024 1 1 1 1 1 1 1 1 1 1 1 0 FFFFEFD1
1025 40000000 40000000 40000000 40000000 40000000 40000000
40000000 40000000 40000000 40000000 40000000 1 40001025
1026 1 1 1 1 1 1 1 1 1 1 1 2 101D
1027 1 1 1 1 1 1 1 1 1 1 1 3 1020

// ==== src.f ====
common/fc_pkg.sv
intake/weight_store.sv
intake/vector_intake.sv
adder_tree/sign_adder_tree.sv
result_fifo/result_fifo.sv
src/fc_top.sv
dv/fc_tb.sv

// ==== Makefile ====
# Verilator build and run for the fully connected layer testbench.

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f src.f --top-module fc_tb -Mdir obj_dir -o fc_tb_sim

run: compile
	./obj_dir/fc_tb_sim > sim.log 2>&1; cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
